// ==== mreg_config.svh ====
`ifndef MREG_CONFIG_SVH
`define MREG_CONFIG_SVH

// data word width, memory and registers
`define MREG_DATA_W  32

// word address on the memory bus
`define MREG_ADDR_W  16

// instruction word as presented on instr
`define MREG_INSTR_W 24

// register number field
`define MREG_REG_W   4

// opcode field
`define MREG_OPC_W   4

// pointer step field
`define MREG_STEP_W  2

`endif

// ==== mreg_pkg.sv ====
`include "mreg_config.svh"

package mreg_pkg;

  typedef logic [`MREG_DATA_W-1:0]  word_t;
  typedef logic [`MREG_ADDR_W-1:0]  addr_t;
  typedef logic [`MREG_INSTR_W-1:0] instr_t;
  typedef logic [`MREG_REG_W-1:0]   reg_num_t;
  typedef logic [`MREG_OPC_W-1:0]   alu_op_t;
  typedef logic [`MREG_STEP_W-1:0]  step_t;
  typedef logic [1:0]               reg_op_t;
  typedef logic                     slot_t;

  // alu opcodes, anything above xor is illegal
  localparam alu_op_t OP_MOV = 4'd0;
  localparam alu_op_t OP_ADD = 4'd1;
  localparam alu_op_t OP_SUB = 4'd2;
  localparam alu_op_t OP_AND = 4'd3;
  localparam alu_op_t OP_OR  = 4'd4;
  localparam alu_op_t OP_XOR = 4'd5;

  // post step of a pointer, 3 behaves as none
  localparam step_t STEP_NONE = 2'd0;
  localparam step_t STEP_INC  = 2'd1;
  localparam step_t STEP_DEC  = 2'd2;

  // one memory-register operation
  localparam reg_op_t REG_OP_READ   = 2'd0;
  localparam reg_op_t REG_OP_READ_P = 2'd1;
  localparam reg_op_t REG_OP_WRITE  = 2'd2;
  localparam reg_op_t REG_OP_STEP   = 2'd3;

  localparam slot_t SLOT_SRC = 1'b0;
  localparam slot_t SLOT_DST = 1'b1;

  typedef enum logic [3:0] {
    IDLE, RD_SRC, RD_SRC_P, RD_DST, RD_DST_P,
    EXEC, WR_RES, STEP_SRC, STEP_DST, FINISH
  } seq_state_t;

endpackage

// ==== mreg_decode.sv ====
`timescale 1ns/1ps

module mreg_decode (
  input  logic               clk,
  input  logic               rst,
  input  mreg_pkg::instr_t   instr,
  input  logic               accept,
  output mreg_pkg::alu_op_t  opcode,
  output mreg_pkg::reg_num_t dst,
  output mreg_pkg::reg_num_t src,
  output logic               dst_ptr,
  output logic               src_ptr,
  output mreg_pkg::step_t    dst_step,
  output mreg_pkg::step_t    src_step,
  output logic               need_dst_read,
  output logic               need_dst_deref,
  output logic               illegal
);

  // raw fields of the incoming word
  // layout from msb: opcode, dst, src, dst_ptr, dst_step, src_ptr, src_step
  mreg_pkg::step_t raw_dst_step;
  mreg_pkg::step_t raw_src_step;

  assign raw_dst_step = instr[10:9];
  assign raw_src_step = instr[7:6];

  // register numbers are payload
  always_ff @(posedge clk) begin
    if (accept) begin
      dst <= instr[19:16];
      src <= instr[15:12];
    end
  end

  // mode bits steer the sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      opcode   <= mreg_pkg::OP_MOV;
      dst_ptr  <= 1'b0;
      src_ptr  <= 1'b0;
      dst_step <= mreg_pkg::STEP_NONE;
      src_step <= mreg_pkg::STEP_NONE;
    end else if (accept) begin
      opcode  <= instr[23:20];
      dst_ptr <= instr[11];
      src_ptr <= instr[8];
      // steps only apply to pointer operands
      // code 3 folds into none here
      if (instr[11] && raw_dst_step != 2'd3)
        dst_step <= raw_dst_step;
      else
        dst_step <= mreg_pkg::STEP_NONE;
      if (instr[8] && raw_src_step != 2'd3)
        src_step <= raw_src_step;
      else
        src_step <= mreg_pkg::STEP_NONE;
    end
  end

  // mov direct never looks at the old destination
  // mov through a pointer still needs the pointer value
  assign need_dst_read = (opcode != mreg_pkg::OP_MOV) || dst_ptr;

  // old destination value only matters when it is an alu input
  assign need_dst_deref = (opcode != mreg_pkg::OP_MOV) && dst_ptr;

  // opcodes past xor are not defined
  assign illegal = opcode > mreg_pkg::OP_XOR;

endmodule

// ==== mreg_operand_manager.sv ====
`timescale 1ns/1ps
`include "mreg_config.svh"

module mreg_operand_manager (
  input  logic               clk,
  input  logic               rst,
  input  mreg_pkg::addr_t    base_addr,
  input  mreg_pkg::reg_op_t  reg_op,
  input  mreg_pkg::slot_t    slot,
  input  logic               op_start,
  input  mreg_pkg::reg_num_t dst,
  input  mreg_pkg::reg_num_t src,
  input  logic               dst_ptr,
  input  mreg_pkg::step_t    dst_step,
  input  mreg_pkg::step_t    src_step,
  input  mreg_pkg::word_t    result,
  input  mreg_pkg::word_t    bus_rdata,
  input  logic               bus_done,
  output logic               op_done,
  output mreg_pkg::word_t    operand_a,
  output mreg_pkg::word_t    operand_b,
  output logic               bus_read,
  output logic               bus_write,
  output mreg_pkg::addr_t    bus_addr,
  output mreg_pkg::word_t    bus_wdata
);

  // per slot: raw register word and the operand value
  mreg_pkg::word_t    ptr_val [2];
  mreg_pkg::word_t    opnd [2];

  // operation in progress
  mreg_pkg::reg_op_t  cur_op;
  mreg_pkg::slot_t    cur_slot;

  mreg_pkg::reg_num_t reg_num;
  mreg_pkg::step_t    step;
  mreg_pkg::word_t    ptr_sel;
  mreg_pkg::word_t    ptr_stepped;
  mreg_pkg::addr_t    reg_addr;
  mreg_pkg::addr_t    next_addr;
  mreg_pkg::word_t    next_wdata;
  logic               pending;

  // slot picks register number, step and pointer
  assign reg_num = (slot == mreg_pkg::SLOT_DST) ? dst : src;
  assign step    = (slot == mreg_pkg::SLOT_DST) ? dst_step : src_step;
  assign ptr_sel = ptr_val[slot];

  // registers live in memory at base + number
  assign reg_addr = base_addr + mreg_pkg::addr_t'(reg_num);

  // post inc / dec of the pointer
  always_comb begin
    case (step)
      mreg_pkg::STEP_INC: ptr_stepped = ptr_sel + 1'b1;
      mreg_pkg::STEP_DEC: ptr_stepped = ptr_sel - 1'b1;
      default:            ptr_stepped = ptr_sel;
    endcase
  end

  // address of the coming request
  always_comb begin
    case (reg_op)
      mreg_pkg::REG_OP_READ_P: begin
        next_addr = ptr_sel[`MREG_ADDR_W-1:0];
      end
      mreg_pkg::REG_OP_WRITE: begin
        // indirect destination goes through the saved pointer
        if (dst_ptr)
          next_addr = ptr_val[mreg_pkg::SLOT_DST][`MREG_ADDR_W-1:0];
        else
          next_addr = base_addr + mreg_pkg::addr_t'(dst);
      end
      default: begin
        next_addr = reg_addr;
      end
    endcase
  end

  // step writes the pointer back, write carries the alu result
  assign next_wdata = (reg_op == mreg_pkg::REG_OP_STEP) ? ptr_stepped : result;

  assign pending = bus_read | bus_write;

  // a is the destination side, b the source side
  assign operand_a = opnd[mreg_pkg::SLOT_DST];
  assign operand_b = opnd[mreg_pkg::SLOT_SRC];

  // request/done handshake
  // request rises the cycle after op_start, held until bus_done
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_read  <= 1'b0;
      bus_write <= 1'b0;
      op_done   <= 1'b0;
    end else begin
      op_done <= 1'b0;
      if (op_start) begin
        bus_read  <= (reg_op == mreg_pkg::REG_OP_READ) ||
                     (reg_op == mreg_pkg::REG_OP_READ_P);
        bus_write <= (reg_op == mreg_pkg::REG_OP_WRITE) ||
                     (reg_op == mreg_pkg::REG_OP_STEP);
      end else if (pending && bus_done) begin
        // drop the request, report one cycle after done
        bus_read  <= 1'b0;
        bus_write <= 1'b0;
        op_done   <= 1'b1;
      end
    end
  end

  // address and data frozen for the whole request
  always_ff @(posedge clk) begin
    if (op_start) begin
      bus_addr  <= next_addr;
      bus_wdata <= next_wdata;
      cur_op    <= reg_op;
      cur_slot  <= slot;
    end
  end

  // read data valid in the done cycle
  always_ff @(posedge clk) begin
    if (bus_read && bus_done) begin
      case (cur_op)
        mreg_pkg::REG_OP_READ: begin
          // register word is both operand and possible pointer
          ptr_val[cur_slot] <= bus_rdata;
          opnd[cur_slot]    <= bus_rdata;
        end
        mreg_pkg::REG_OP_READ_P: begin
          opnd[cur_slot] <= bus_rdata;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== mreg_execute.sv ====
`timescale 1ns/1ps

module mreg_execute (
  input  logic              clk,
  input  logic              rst,
  input  logic              exec_start,
  input  mreg_pkg::alu_op_t opcode,
  input  mreg_pkg::word_t   operand_a,
  input  mreg_pkg::word_t   operand_b,
  output mreg_pkg::word_t   result,
  output logic              result_zero
);

  mreg_pkg::word_t alu_val;

  // a is the old destination, b the source
  always_comb begin
    case (opcode)
      mreg_pkg::OP_MOV: alu_val = operand_b;
      mreg_pkg::OP_ADD: alu_val = operand_a + operand_b;
      mreg_pkg::OP_SUB: alu_val = operand_a - operand_b;
      mreg_pkg::OP_AND: alu_val = operand_a & operand_b;
      mreg_pkg::OP_OR:  alu_val = operand_a | operand_b;
      mreg_pkg::OP_XOR: alu_val = operand_a ^ operand_b;
      // never reached, sequencer skips illegal opcodes
      default:          alu_val = '0;
    endcase
  end

  // result held until the next exec
  always_ff @(posedge clk) begin
    if (exec_start) begin
      result <= alu_val;
    end
  end

  // zero flag follows the latched result
  always_ff @(posedge clk) begin
    if (rst) begin
      result_zero <= 1'b0;
    end else if (exec_start) begin
      result_zero <= (alu_val == '0);
    end
  end

endmodule

// ==== mreg_sequencer.sv ====
`timescale 1ns/1ps

module mreg_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  logic              op_done,
  input  logic              need_dst_read,
  input  logic              need_dst_deref,
  input  logic              illegal,
  input  logic              src_ptr,
  input  mreg_pkg::step_t   src_step,
  input  mreg_pkg::step_t   dst_step,
  output logic              instr_ready,
  output logic              accept,
  output logic              op_start,
  output logic              exec_start,
  output logic              done,
  output logic              err,
  output mreg_pkg::reg_op_t reg_op,
  output mreg_pkg::slot_t   slot
);

  mreg_pkg::seq_state_t state;
  mreg_pkg::seq_state_t state_next;
  // instruction taken last cycle, fields now decoded
  logic accepted;
  logic step_src;
  logic step_dst;
  logic enter_op;

  assign instr_ready = (state == mreg_pkg::IDLE) && !accepted;
  assign accept      = instr_valid && instr_ready;
  assign exec_start  = (state == mreg_pkg::EXEC);

  // dst_step is already none for a direct destination
  assign step_src = src_ptr && (src_step != mreg_pkg::STEP_NONE);
  assign step_dst = dst_step != mreg_pkg::STEP_NONE;

  always_comb begin
    state_next = state;
    case (state)
      mreg_pkg::IDLE:
        if (accepted)
          state_next = illegal ? mreg_pkg::FINISH : mreg_pkg::RD_SRC;
      mreg_pkg::RD_SRC:
        if (op_done) begin
          if (src_ptr)
            state_next = mreg_pkg::RD_SRC_P;
          else
            state_next = need_dst_read ? mreg_pkg::RD_DST : mreg_pkg::EXEC;
        end
      mreg_pkg::RD_SRC_P:
        if (op_done)
          state_next = need_dst_read ? mreg_pkg::RD_DST : mreg_pkg::EXEC;
      mreg_pkg::RD_DST:
        if (op_done)
          state_next = need_dst_deref ? mreg_pkg::RD_DST_P : mreg_pkg::EXEC;
      mreg_pkg::RD_DST_P:
        if (op_done)
          state_next = mreg_pkg::EXEC;
      // single cycle alu
      mreg_pkg::EXEC:
        state_next = mreg_pkg::WR_RES;
      mreg_pkg::WR_RES:
        if (op_done) begin
          if (step_src)
            state_next = mreg_pkg::STEP_SRC;
          else
            state_next = step_dst ? mreg_pkg::STEP_DST : mreg_pkg::FINISH;
        end
      mreg_pkg::STEP_SRC:
        if (op_done)
          state_next = step_dst ? mreg_pkg::STEP_DST : mreg_pkg::FINISH;
      mreg_pkg::STEP_DST:
        if (op_done)
          state_next = mreg_pkg::FINISH;
      default:
        state_next = mreg_pkg::IDLE;
    endcase
  end

  // operation code and slot per bus state
  always_comb begin
    reg_op = mreg_pkg::REG_OP_READ;
    slot   = mreg_pkg::SLOT_SRC;
    case (state)
      mreg_pkg::RD_SRC_P: reg_op = mreg_pkg::REG_OP_READ_P;
      mreg_pkg::RD_DST:   slot   = mreg_pkg::SLOT_DST;
      mreg_pkg::RD_DST_P: begin
        reg_op = mreg_pkg::REG_OP_READ_P;
        slot   = mreg_pkg::SLOT_DST;
      end
      mreg_pkg::WR_RES: begin
        reg_op = mreg_pkg::REG_OP_WRITE;
        slot   = mreg_pkg::SLOT_DST;
      end
      mreg_pkg::STEP_SRC: reg_op = mreg_pkg::REG_OP_STEP;
      mreg_pkg::STEP_DST: begin
        reg_op = mreg_pkg::REG_OP_STEP;
        slot   = mreg_pkg::SLOT_DST;
      end
      default: begin
      end
    endcase
  end

  // one start pulse on entry to each bus state
  assign enter_op = (state_next != state) &&
                    (state_next inside {mreg_pkg::RD_SRC, mreg_pkg::RD_SRC_P,
                                        mreg_pkg::RD_DST, mreg_pkg::RD_DST_P,
                                        mreg_pkg::WR_RES, mreg_pkg::STEP_SRC,
                                        mreg_pkg::STEP_DST});

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mreg_pkg::IDLE;
      accepted <= 1'b0;
      op_start <= 1'b0;
      done     <= 1'b0;
      err      <= 1'b0;
    end else begin
      state    <= state_next;
      accepted <= accept;
      op_start <= enter_op;
      // completion pulse the cycle after finish
      done     <= (state == mreg_pkg::FINISH);
      err      <= (state == mreg_pkg::FINISH) && illegal;
    end
  end

endmodule

// ==== mreg_core.sv ====
`timescale 1ns/1ps

module mreg_core (
  input  logic             clk,
  input  logic             rst,
  input  mreg_pkg::instr_t instr,
  input  logic             instr_valid,
  output logic             instr_ready,
  input  mreg_pkg::addr_t  base_addr,
  output logic             bus_read,
  output logic             bus_write,
  output mreg_pkg::addr_t  bus_addr,
  output mreg_pkg::word_t  bus_wdata,
  input  mreg_pkg::word_t  bus_rdata,
  input  logic             bus_done,
  output logic             done,
  output logic             err,
  output mreg_pkg::word_t  result,
  output logic             result_zero
);

  // decoded fields
  mreg_pkg::alu_op_t  opcode;
  mreg_pkg::reg_num_t dst;
  mreg_pkg::reg_num_t src;
  logic               dst_ptr;
  logic               src_ptr;
  mreg_pkg::step_t    dst_step;
  mreg_pkg::step_t    src_step;
  logic               need_dst_read;
  logic               need_dst_deref;
  logic               illegal;

  // sequencer to manager and alu
  logic               accept;
  logic               op_start;
  logic               op_done;
  logic               exec_start;
  mreg_pkg::reg_op_t  reg_op;
  mreg_pkg::slot_t    slot;

  // operands into the alu
  mreg_pkg::word_t    operand_a;
  mreg_pkg::word_t    operand_b;

  mreg_decode u_decode (
    .clk            (clk),
    .rst            (rst),
    .instr          (instr),
    .accept         (accept),
    .opcode         (opcode),
    .dst            (dst),
    .src            (src),
    .dst_ptr        (dst_ptr),
    .src_ptr        (src_ptr),
    .dst_step       (dst_step),
    .src_step       (src_step),
    .need_dst_read  (need_dst_read),
    .need_dst_deref (need_dst_deref),
    .illegal        (illegal)
  );

  mreg_sequencer u_sequencer (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .op_done        (op_done),
    .need_dst_read  (need_dst_read),
    .need_dst_deref (need_dst_deref),
    .illegal        (illegal),
    .src_ptr        (src_ptr),
    .src_step       (src_step),
    .dst_step       (dst_step),
    .instr_ready    (instr_ready),
    .accept         (accept),
    .op_start       (op_start),
    .exec_start     (exec_start),
    .done           (done),
    .err            (err),
    .reg_op         (reg_op),
    .slot           (slot)
  );

  mreg_operand_manager u_operand_manager (
    .clk       (clk),
    .rst       (rst),
    .base_addr (base_addr),
    .reg_op    (reg_op),
    .slot      (slot),
    .op_start  (op_start),
    .dst       (dst),
    .src       (src),
    .dst_ptr   (dst_ptr),
    .dst_step  (dst_step),
    .src_step  (src_step),
    .result    (result),
    .bus_rdata (bus_rdata),
    .bus_done  (bus_done),
    .op_done   (op_done),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .bus_read  (bus_read),
    .bus_write (bus_write),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata)
  );

  mreg_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .exec_start  (exec_start),
    .opcode      (opcode),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .result      (result),
    .result_zero (result_zero)
  );

endmodule

// ==== mreg_core_properties.sv ====
`timescale 1ns/1ps

module mreg_core_properties (
  input logic            clk,
  input logic            rst,
  input logic            instr_valid,
  input logic            instr_ready,
  input logic            bus_read,
  input logic            bus_write,
  input mreg_pkg::addr_t bus_addr,
  input mreg_pkg::word_t bus_wdata,
  input logic            bus_done,
  input logic            done
);

  // accepted and not yet completed
  logic busy;

  // number of failed assertions so far
  int fail_count = 0;

  // a new accept in the done cycle keeps it set
  always_ff @(posedge clk) begin
    if (rst)
      busy <= 1'b0;
    else if (instr_valid && instr_ready)
      busy <= 1'b1;
    else if (done)
      busy <= 1'b0;
  end

  // one direction per request
  a_no_read_write : assert property (@(posedge clk) disable iff (rst)
    !(bus_read && bus_write))
    else begin
      fail_count++;
      $error("bus_read and bus_write high together");
    end

  // request held with frozen address and data until done
  a_req_stable : assert property (@(posedge clk) disable iff (rst)
    (bus_read || bus_write) && !bus_done |=>
      (bus_read || bus_write) && $stable(bus_addr) && $stable(bus_wdata))
    else begin
      fail_count++;
      $error("bus request changed before bus_done");
    end

  // no second command while one is running
  a_ready_low_busy : assert property (@(posedge clk) disable iff (rst)
    busy && !done |-> !instr_ready)
    else begin
      fail_count++;
      $error("instr_ready high with an instruction in flight");
    end

  // completion is a single pulse
  a_done_pulse : assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else begin
      fail_count++;
      $error("done held longer than one cycle");
    end

endmodule

bind mreg_core mreg_core_properties u_mreg_core_properties (
  .clk         (clk),
  .rst         (rst),
  .instr_valid (instr_valid),
  .instr_ready (instr_ready),
  .bus_read    (bus_read),
  .bus_write   (bus_write),
  .bus_addr    (bus_addr),
  .bus_wdata   (bus_wdata),
  .bus_done    (bus_done),
  .done        (done)
);

// ==== tb_mreg_core.sv ====
`timescale 1ns/1ps
`include "mreg_config.svh"

module tb_mreg_core;

  localparam int CLK_PERIOD   = 40;
  localparam int MEM_WORDS    = 1 << `MREG_ADDR_W;
  localparam int NUM_RANDOM   = 40;
  // five directed instructions plus the random mix
  localparam int NUM_INSTR    = NUM_RANDOM + 5;
  // rd_src, rd_src_p, rd_dst, rd_dst_p, wr_res, step_src, step_dst
  localparam int MAX_OPS      = 7;
  localparam int MAX_LAT      = 3;
  // op_start, first request cycle, latency, op_done, next state
  localparam int OP_CYCLES    = MAX_LAT + 4;
  localparam int INSTR_CYCLES = MAX_OPS * OP_CYCLES + 8;
  localparam int DONE_TIMEOUT = 2 * INSTR_CYCLES;
  // double margin, plus reset
  localparam int WATCHDOG_NS  = (2 * NUM_INSTR * INSTR_CYCLES + 20) * CLK_PERIOD;

  logic             clk;
  logic             rst;
  mreg_pkg::instr_t instr;
  logic             instr_valid;
  logic             instr_ready;
  mreg_pkg::addr_t  base_addr;
  logic             bus_read;
  logic             bus_write;
  mreg_pkg::addr_t  bus_addr;
  mreg_pkg::word_t  bus_wdata;
  mreg_pkg::word_t  bus_rdata;
  logic             bus_done;
  logic             done;
  logic             err;
  mreg_pkg::word_t  result;
  logic             result_zero;

  // memory behind the bus, and the model's copy
  mreg_pkg::word_t  mem [MEM_WORDS];
  mreg_pkg::word_t  ref_mem [MEM_WORDS];

  // bus monitor logs, cleared per instruction
  mreg_pkg::addr_t  rd_log [$];
  mreg_pkg::addr_t  wr_log [$];
  int               req_count;

  integer           seed = 32'h200b635b;
  logic             serving;
  int               wait_left;

  int               err_count;
  int               check_count;
  int               test_count;

  // sampled in the done cycle
  logic             got_done;
  mreg_pkg::word_t  got_res;
  logic             got_err;
  logic             got_zero;

  mreg_core u_mreg_core (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .base_addr   (base_addr),
    .bus_read    (bus_read),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_rdata   (bus_rdata),
    .bus_done    (bus_done),
    .done        (done),
    .err         (err),
    .result      (result),
    .result_zero (result_zero)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory responder, 0..3 wait cycles per request
  always @(negedge clk) begin
    if (bus_done) begin
      bus_done = 1'b0;
    end else if (bus_read || bus_write) begin
      if (!serving) begin
        // each request counted once, as soon as it shows up
        req_count++;
        serving   = 1'b1;
        wait_left = $unsigned($random(seed)) % (MAX_LAT + 1);
      end
      if (wait_left == 0) begin
        if (bus_write) begin
          mem[bus_addr] = bus_wdata;
          wr_log.push_back(bus_addr);
        end else begin
          bus_rdata = mem[bus_addr];
          rd_log.push_back(bus_addr);
        end
        bus_done = 1'b1;
        serving  = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR %s", msg);
  endtask

  task automatic check_word(input string name, input mreg_pkg::word_t got,
                            input mreg_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input mreg_pkg::addr_t got,
                            input mreg_pkg::addr_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // field order from msb, low six bits ignored by the DUT
  function automatic mreg_pkg::instr_t make_instr(
    input mreg_pkg::alu_op_t op, input mreg_pkg::reg_num_t rd, input mreg_pkg::reg_num_t rs,
    input logic dp, input mreg_pkg::step_t ds, input logic sp, input mreg_pkg::step_t ss);
    return {op, rd, rs, dp, ds, sp, ss, 6'b0};
  endfunction

  // a is the old destination, b the source
  function automatic mreg_pkg::word_t alu_model(input mreg_pkg::alu_op_t op,
                                                input mreg_pkg::word_t a,
                                                input mreg_pkg::word_t b);
    case (op)
      mreg_pkg::OP_ADD: return a + b;
      mreg_pkg::OP_SUB: return a - b;
      mreg_pkg::OP_AND: return a & b;
      mreg_pkg::OP_OR:  return a | b;
      mreg_pkg::OP_XOR: return a ^ b;
      default:          return b;
    endcase
  endfunction

  // true only for a real inc or dec, code 3 counts as none
  function automatic logic is_step(input mreg_pkg::step_t s);
    return (s == mreg_pkg::STEP_INC) || (s == mreg_pkg::STEP_DEC);
  endfunction

  function automatic mreg_pkg::word_t step_value(input mreg_pkg::word_t p,
                                                 input mreg_pkg::step_t s);
    if (s == mreg_pkg::STEP_INC)
      return p + 1;
    if (s == mreg_pkg::STEP_DEC)
      return p - 1;
    return p;
  endfunction

  // applies one instruction to ref_mem in bus order
  task automatic model_instr(input mreg_pkg::instr_t ins, input mreg_pkg::addr_t base,
                             output mreg_pkg::word_t exp_res, output logic exp_err);
    mreg_pkg::alu_op_t op;
    mreg_pkg::addr_t   ra_dst;
    mreg_pkg::addr_t   ra_src;
    mreg_pkg::word_t   s_ptr;
    mreg_pkg::word_t   d_ptr;
    mreg_pkg::word_t   a;
    mreg_pkg::word_t   b;
    op      = ins[23:20];
    ra_dst  = base + mreg_pkg::addr_t'(ins[19:16]);
    ra_src  = base + mreg_pkg::addr_t'(ins[15:12]);
    exp_err = op > mreg_pkg::OP_XOR;
    exp_res = '0;
    if (!exp_err) begin
      s_ptr = ref_mem[ra_src];
      b     = ins[8] ? ref_mem[s_ptr[`MREG_ADDR_W-1:0]] : s_ptr;
      d_ptr = '0;
      a     = '0;
      // mov direct skips the destination read
      if (op != mreg_pkg::OP_MOV || ins[11]) begin
        d_ptr = ref_mem[ra_dst];
        a     = d_ptr;
      end
      if (op != mreg_pkg::OP_MOV && ins[11])
        a = ref_mem[d_ptr[`MREG_ADDR_W-1:0]];
      exp_res = alu_model(op, a, b);
      if (ins[11])
        ref_mem[d_ptr[`MREG_ADDR_W-1:0]] = exp_res;
      else
        ref_mem[ra_dst] = exp_res;
      // steps use the pointer values read before the result write
      if (ins[8] && is_step(ins[7:6]))
        ref_mem[ra_src] = step_value(s_ptr, ins[7:6]);
      if (ins[11] && is_step(ins[10:9]))
        ref_mem[ra_dst] = step_value(d_ptr, ins[10:9]);
    end
  endtask

  task automatic clear_logs();
    rd_log.delete();
    wr_log.delete();
    req_count = 0;
  endtask

  // hand over one instruction and wait for done
  task automatic run_instr(input mreg_pkg::instr_t ins, input mreg_pkg::addr_t base);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!instr_ready && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    base_addr   = base;
    instr       = ins;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    got_done = done;
    got_res  = result;
    got_err  = err;
    got_zero = result_zero;
    if (!got_done)
      report_error($sformatf("no done within %0d cycles for instr %h", DONE_TIMEOUT, ins));
  endtask

  // number and order of bus writes
  task automatic check_writes(input int n, input mreg_pkg::addr_t first,
                              input mreg_pkg::addr_t second);
    if (wr_log.size() != n) begin
      report_error($sformatf("expected %0d bus writes, saw %0d", n, wr_log.size()));
    end else begin
      check_addr("first write bus_addr", wr_log[0], first);
      if (n > 1)
        check_addr("second write bus_addr", wr_log[1], second);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before)
      $display("test %s passed", name);
    else
      $display("test %s failed with %0d errors", name, err_count - errs_before);
  endtask

  task automatic test_direct_add();
    int              errs_before;
    mreg_pkg::addr_t base;
    errs_before = err_count;
    base = 16'h0040;
    mem[base + 16'd3] = 32'd100;
    mem[base + 16'd5] = 32'd23;
    clear_logs();
    run_instr(make_instr(mreg_pkg::OP_ADD, 4'd3, 4'd5, 1'b0, mreg_pkg::STEP_NONE,
                         1'b0, mreg_pkg::STEP_NONE), base);
    check_bit("done", got_done, 1'b1);
    check_bit("err", got_err, 1'b0);
    check_word("result", got_res, 32'd123);
    check_bit("result_zero", got_zero, 1'b0);
    check_word("mem[base+3]", mem[base + 16'd3], 32'd123);
    check_writes(1, base + 16'd3, '0);
    end_test("direct_add", errs_before);
  endtask

  task automatic test_src_ptr_inc();
    int              errs_before;
    mreg_pkg::addr_t base;
    errs_before = err_count;
    base = 16'h0040;
    mem[base + 16'd1] = 32'd1000;
    mem[base + 16'd2] = 32'h0000_0200;
    mem[16'h0200]     = 32'd58;
    clear_logs();
    // sub r1, [r2]+
    run_instr(make_instr(mreg_pkg::OP_SUB, 4'd1, 4'd2, 1'b0, mreg_pkg::STEP_NONE,
                         1'b1, mreg_pkg::STEP_INC), base);
    check_bit("done", got_done, 1'b1);
    check_word("result", got_res, 32'd942);
    check_word("mem[base+1]", mem[base + 16'd1], 32'd942);
    check_word("mem[base+2]", mem[base + 16'd2], 32'h0000_0201);
    check_writes(2, base + 16'd1, base + 16'd2);
    end_test("src_ptr_inc_sub", errs_before);
  endtask

  task automatic test_dst_ptr_dec();
    int              errs_before;
    mreg_pkg::addr_t base;
    errs_before = err_count;
    base = 16'h0040;
    mem[base + 16'd4] = 32'h0000_0300;
    mem[16'h0300]     = 32'hcafe_f00d;
    mem[base + 16'd6] = 32'hcafe_f00d;
    clear_logs();
    // xor [r4]-, r6 with equal values gives zero
    run_instr(make_instr(mreg_pkg::OP_XOR, 4'd4, 4'd6, 1'b1, mreg_pkg::STEP_DEC,
                         1'b0, mreg_pkg::STEP_NONE), base);
    check_bit("done", got_done, 1'b1);
    check_word("result", got_res, 32'h0);
    check_bit("result_zero", got_zero, 1'b1);
    check_word("mem[0300]", mem[16'h0300], 32'h0);
    check_word("mem[base+4]", mem[base + 16'd4], 32'h0000_02ff);
    check_writes(2, 16'h0300, base + 16'd4);
    end_test("dst_ptr_dec_xor", errs_before);
  endtask

  task automatic test_mov_and_illegal();
    int              errs_before;
    mreg_pkg::addr_t base;
    errs_before = err_count;
    base = 16'h0040;
    mem[base + 16'd7] = 32'h0000_dead;
    mem[base + 16'd8] = 32'h1234_5678;
    clear_logs();
    run_instr(make_instr(mreg_pkg::OP_MOV, 4'd7, 4'd8, 1'b0, mreg_pkg::STEP_NONE,
                         1'b0, mreg_pkg::STEP_NONE), base);
    check_word("result", got_res, 32'h1234_5678);
    check_word("mem[base+7]", mem[base + 16'd7], 32'h1234_5678);
    foreach (rd_log[k]) begin
      if (rd_log[k] == base + 16'd7)
        report_error("mov with a direct destination read the destination register");
    end
    // opcode 12 is undefined
    clear_logs();
    run_instr(make_instr(4'hc, 4'd7, 4'd8, 1'b0, mreg_pkg::STEP_NONE,
                         1'b0, mreg_pkg::STEP_NONE), base);
    check_bit("done", got_done, 1'b1);
    check_bit("err", got_err, 1'b1);
    if (req_count != 0)
      report_error($sformatf("illegal opcode made %0d bus requests", req_count));
    end_test("mov_and_illegal", errs_before);
  endtask

  task automatic test_random_mix();
    int                errs_before;
    int                mismatches;
    logic [31:0]       rnd;
    mreg_pkg::alu_op_t op;
    mreg_pkg::instr_t  ins;
    mreg_pkg::addr_t   base;
    mreg_pkg::word_t   exp_res;
    logic              exp_err;
    errs_before = err_count;
    mismatches  = 0;
    for (int a = 0; a < MEM_WORDS; a++)
      ref_mem[a] = mem[a];
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd = $random(seed);
      // mostly legal opcodes, now and then an undefined one
      op  = (rnd[4:0] < 5'd30) ? mreg_pkg::alu_op_t'(rnd[4:0] % 6) : {3'b111, rnd[0]};
      ins = {op, rnd[24:5]};
      // half the instructions use a second register bank
      base = i[0] ? 16'hc000 : 16'h0100;
      model_instr(ins, base, exp_res, exp_err);
      run_instr(ins, base);
      check_bit("err", got_err, exp_err);
      if (!exp_err) begin
        check_word("result", got_res, exp_res);
        check_bit("result_zero", got_zero, exp_res == '0);
      end
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (mem[a] !== ref_mem[a] && mismatches < 8) begin
        mismatches++;
        check_word($sformatf("mem[%h]", a[`MREG_ADDR_W-1:0]), mem[a], ref_mem[a]);
      end
    end
    end_test("random_mix", errs_before);
  endtask

  initial begin
    int errs_before;
    rst         = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    base_addr   = '0;
    bus_rdata   = '0;
    bus_done    = 1'b0;
    serving     = 1'b0;
    wait_left   = 0;
    req_count   = 0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    // fill pattern depends on every address bit
    for (int a = 0; a < MEM_WORDS; a++)
      mem[a] = {mreg_pkg::addr_t'(a) ^ 16'h5aa5, ~mreg_pkg::addr_t'(a)};
    // five rising edges with reset held
    repeat (5) @(posedge clk);
    @(negedge clk);
    errs_before = err_count;
    check_bit("instr_ready", instr_ready, 1'b1);
    check_bit("bus_read", bus_read, 1'b0);
    check_bit("bus_write", bus_write, 1'b0);
    check_bit("done", done, 1'b0);
    rst = 1'b0;
    end_test("reset_state", errs_before);
    test_direct_add();
    test_src_ptr_inc();
    test_dst_ptr_dec();
    test_mov_and_illegal();
    test_random_mix();
    if (u_mreg_core.u_mreg_core_properties.fail_count != 0)
      report_error($sformatf("%0d bus protocol assertions failed",
                             u_mreg_core.u_mreg_core_properties.fail_count));
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== mreg_core.f ====
+incdir+.
mreg_pkg.sv
mreg_decode.sv
mreg_operand_manager.sv
mreg_execute.sv
mreg_sequencer.sv
mreg_core.sv
mreg_core_properties.sv
tb_mreg_core.sv
